/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cache
RTL_TOP    := cache_top
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '*** FAILED ***' $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cache_ctrl.sv */
// lookup / write-back / allocate FSM; one request in flight, request held until stall drops
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic  clk,
    input  logic  proc_reset,
    input  logic  proc_read,
    input  logic  proc_write,
    input  logic  mem_ready,
    output logic  proc_stall,
    output logic  mem_read,
    output logic  mem_write,
    cache_if.ctrl cif
);

    import cache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;

    // ------------------------------------------------------------------------
    // state register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // next state and outputs
    // ------------------------------------------------------------------------
    always_comb begin
        state_d       = state_q;
        proc_stall    = 1'b1;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        cif.hit_read  = 1'b0;
        cif.hit_write = 1'b0;
        cif.clean     = 1'b0;
        cif.fill      = 1'b0;
        cif.wb_sel    = 1'b0;
        case (state_q)
            IDLE: state_d = COMP;
            COMP: begin
                if (!proc_read && !proc_write) begin
                    proc_stall = 1'b0;  // nothing asked
                end else if (cif.hit) begin
                    proc_stall    = 1'b0;
                    cif.hit_read  = proc_read;
                    cif.hit_write = proc_write;
                end else if (cif.victim_dirty) begin
                    state_d = WRITE;
                end else begin
                    state_d = ALLOC;
                end
            end
            WRITE: begin
                cif.wb_sel = 1'b1;
                mem_write  = !mem_ready;
                if (mem_ready) begin
                    cif.clean = 1'b1;
                    state_d   = ALLOC;
                end
            end
            ALLOC: begin
                mem_read = !mem_ready;
                if (mem_ready) begin
                    cif.fill = 1'b1;
                    state_d  = COMP;  // request hits on the retry
                end
            end
            default: state_d = IDLE;
        endcase
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write both high");

    a_proc_excl: assert property (@(posedge clk) disable iff (proc_reset)
        !(proc_read && proc_write))
        else $error("proc_read and proc_write both high");

endmodule

`default_nettype wire

/* cache_if.sv */
// command and status wires between controller and store; all single-cycle or level, no clocking
`timescale 1ns/1ps
`default_nettype none

interface cache_if;

    // controller -> store
    logic hit_read;      // read hit in COMP, touches lru
    logic hit_write;     // write hit, word lands at next edge
    logic clean;         // write-back done, drop victim dirty bit
    logic fill;          // line from memory into victim way
    logic wb_sel;        // mem_addr follows the victim line

    // store -> controller
    logic hit;           // request tag found in indexed set
    logic victim_dirty;  // lru way valid and dirty

    modport ctrl (
        output hit_read,
        output hit_write,
        output clean,
        output fill,
        output wb_sel,
        input  hit,
        input  victim_dirty
    );

    modport store (
        input  hit_read,
        input  hit_write,
        input  clean,
        input  fill,
        input  wb_sel,
        output hit,
        output victim_dirty
    );

endinterface

`default_nettype wire

/* cache_pkg.sv */
// shared widths and types; 30-bit word addresses, 4-word 128-bit lines, fixed at these sizes
`default_nettype none

package cache_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;  // 128
    localparam int ADDR_BITS      = 30;                          // word address

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [ADDR_BITS-1:0] word_addr_t;

    // line address drops the word offset
    typedef logic [ADDR_BITS-$clog2(WORDS_PER_LINE)-1:0] line_addr_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // one cycle after reset
        COMP  = 2'd1,  // tag compare, hits served here
        WRITE = 2'd2,  // dirty victim going out
        ALLOC = 2'd3   // line fill from memory
    } cache_state_e;

endpackage

`default_nettype wire

/* cache_store.sv */
// two-way tag/data store; num_sets must be a power of two >= 2, reads are combinational
`timescale 1ns/1ps
`default_nettype none

module cache_store #(
    parameter int num_sets = 4
) (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  cache_pkg::word_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output cache_pkg::word_t      proc_rdata,
    input  cache_pkg::line_t      mem_rdata,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata,
    cache_if.store                cif
);

    import cache_pkg::*;

    localparam int off_bits = $clog2(WORDS_PER_LINE);
    localparam int idx_bits = $clog2(num_sets);
    localparam int tag_bits = ADDR_BITS - off_bits - idx_bits;

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    logic [num_sets-1:0] valid_q [2];
    logic [num_sets-1:0] dirty_q [2];
    logic [tag_bits-1:0] tag_q   [2][num_sets];
    line_t               line_q  [2][num_sets];
    logic [num_sets-1:0] lru_q;  // 1 bit per set, names the least recent way

    // address fields
    logic [off_bits-1:0] word_off;
    logic [idx_bits-1:0] set_idx;
    logic [tag_bits-1:0] req_tag;

    logic [1:0] way_hit;
    logic       hit_way;   // only meaningful when a way hits
    logic       victim;
    line_t      hit_line;

    assign word_off = proc_addr[off_bits-1:0];
    assign set_idx  = proc_addr[off_bits +: idx_bits];
    assign req_tag  = proc_addr[ADDR_BITS-1 -: tag_bits];

    // ------------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == req_tag);
        end
    end

    assign hit_way  = way_hit[1];
    assign cif.hit  = |way_hit;
    assign hit_line = line_q[hit_way][set_idx];

    // word mux, zero on miss
    assign proc_rdata = cif.hit ? hit_line[word_off*WORD_BITS +: WORD_BITS] : '0;

    // victim is always the lru way, whether or not it is valid
    assign victim           = lru_q[set_idx];
    assign cif.victim_dirty = valid_q[victim][set_idx] && dirty_q[victim][set_idx];

    assign mem_wdata = line_q[victim][set_idx];
    assign mem_addr  = cif.wb_sel ? {tag_q[victim][set_idx], set_idx}
                                  : proc_addr[ADDR_BITS-1:off_bits];

    // ------------------------------------------------------------------------
    // valid, dirty and lru bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;  // way 0 goes first
        end else begin
            if (cif.hit_read || cif.hit_write) begin
                lru_q[set_idx] <= ~hit_way;
            end
            if (cif.hit_write) begin
                dirty_q[hit_way][set_idx] <= 1'b1;
            end
            if (cif.clean) begin
                dirty_q[victim][set_idx] <= 1'b0;
            end
            if (cif.fill) begin
                valid_q[victim][set_idx] <= 1'b1;
                dirty_q[victim][set_idx] <= 1'b0;
                lru_q[set_idx]           <= ~victim;  // filled way is now most recent
            end
        end
    end

    // ------------------------------------------------------------------------
    // tags and line data
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (cif.hit_write) begin
            line_q[hit_way][set_idx][word_off*WORD_BITS +: WORD_BITS] <= proc_wdata;
        end
        if (cif.fill) begin
            line_q[victim][set_idx] <= mem_rdata;
            tag_q[victim][set_idx]  <= req_tag;
        end
    end

    // a fill never leaves the same tag in both ways
    a_single_hit: assert property (@(posedge clk) disable iff (proc_reset)
        !(way_hit[0] && way_hit[1]))
        else $error("both ways hit in set %0d", set_idx);

endmodule

`default_nettype wire

/* cache_top.sv */
// 2-way write-back L1 cache; memory answers with a one-cycle mem_ready, num_sets power of two >= 2
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int num_sets = 4
) (
    input  logic                  clk,
    input  logic                  proc_reset,
    // processor side
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::word_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output logic                  proc_stall,
    output cache_pkg::word_t      proc_rdata,
    // memory side, whole lines
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata,
    input  cache_pkg::line_t      mem_rdata,
    input  logic                  mem_ready
);

    cache_if cif ();

    cache_ctrl u_ctrl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .cif        (cif.ctrl)
    );

    cache_store #(
        .num_sets (num_sets)
    ) u_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .mem_rdata  (mem_rdata),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .cif        (cif.store)
    );

endmodule

`default_nettype wire

/* tb_cache.sv */
// testbench for cache_top with num_sets = 4; all addresses must stay inside the 64-line memory
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    import cache_pkg::*;

    localparam int reset_cycles = 10;
    localparam int num_ops      = 214;  // 1 + 3 + 4 + 6 + 200 processor accesses
    localparam int max_cycles   = num_ops * 12 + reset_cycles;

    logic       clk;
    logic       proc_reset;
    logic       proc_read;
    logic       proc_write;
    word_addr_t proc_addr;
    word_t      proc_wdata;
    logic       proc_stall;
    word_t      proc_rdata;
    logic       mem_read;
    logic       mem_write;
    line_addr_t mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata;
    logic       mem_ready;

    line_t       mem_lines [64];
    word_t       shadow [256];            // one entry per word of the memory model
    logic [31:0] lfsr_q       = 32'd90390;
    int          error_count  = 0;
    int          check_count  = 0;
    int          fill_count   = 0;        // mem_read services started
    int          wb_count     = 0;        // write-backs taken by the memory
    line_addr_t  last_wb_addr = '0;

    cache_top #(.num_sets (4)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);  // one step per bit
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // odd multiplier so every address bit shows up in the word
    function automatic word_t init_pattern(input word_addr_t a);
        return (32'(a) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    // last value written to the word, or its initial pattern if never written
    function automatic word_t expected_word(input word_addr_t a);
        return shadow[a[7:0]];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s at %0t", what, $time);
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the edge that ends the access
    task automatic access(input logic is_write, input word_addr_t addr, input word_t data);
        proc_read  = !is_write;
        proc_write = is_write;
        proc_addr  = addr;
        proc_wdata = data;
        @(negedge clk);
        while (proc_stall) @(negedge clk);
        @(posedge clk);
        #1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // comparing process sampling at the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!proc_reset && !proc_stall) begin
            if (proc_read) begin
                check_value("proc_rdata", proc_rdata, expected_word(proc_addr));
            end
            if (proc_write) begin
                shadow[proc_addr[7:0]] = proc_wdata;  // lands at the next edge
            end
        end
    end

    // ------------------------------------------------------------------------
    // memory model answering after 1 to 4 cycles with a one-cycle mem_ready
    // ------------------------------------------------------------------------
    initial begin : memory_model
        logic       serve_write;
        line_addr_t serve_addr;
        int         latency;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!proc_reset && (mem_read || mem_write)) begin
                serve_write = mem_write;
                serve_addr  = mem_addr;
                latency     = int'(take_bits(2)) + 1;
                if (serve_addr >= 64) begin
                    report_failure("memory access outside the 64-line memory model");
                end
                if (!serve_write) begin
                    fill_count++;
                end
                repeat (latency) @(posedge clk);
                #1;
                mem_ready = 1'b1;
                mem_rdata = mem_lines[serve_addr[5:0]];
                @(negedge clk);
                check_value("mem_read", 32'(mem_read), 32'd0);  // levels drop with mem_ready
                check_value("mem_write", 32'(mem_write), 32'd0);
                if (serve_write) begin
                    check_value("mem_addr", 32'(mem_addr), 32'(serve_addr));
                    for (int w = 0; w < 4; w++) begin
                        check_value("mem_wdata", mem_wdata[w*32 +: 32],
                                    expected_word({serve_addr, 2'(w)}));
                    end
                    mem_lines[serve_addr[5:0]] = mem_wdata;
                    last_wb_addr               = serve_addr;
                    wb_count++;
                end
                @(posedge clk);
                #1;
                mem_ready = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count <= max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run did not finish within %0d cycles", max_cycles);
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("*** FAILED ***");
        $finish;
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int          fills_before;
        int          wbs_before;
        logic [31:0] rnd_op;
        word_addr_t  rnd_addr;
        word_t       rnd_data;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        for (int a = 0; a < 256; a++) begin
            shadow[a]                          = init_pattern(word_addr_t'(a));
            mem_lines[a >> 2][(a & 3)*32 +: 32] = init_pattern(word_addr_t'(a));
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        proc_reset = 1'b0;
        @(negedge clk);
        if (mem_read || mem_write) begin
            report_failure("memory read or write level high right after reset");
        end
        check_value("proc_stall", 32'(proc_stall), 32'd1);  // IDLE cycle
        @(posedge clk);
        #1;
        @(negedge clk);
        check_value("proc_stall", 32'(proc_stall), 32'd0);  // COMP after one cycle
        @(posedge clk);
        #1;

        // first access misses
        fills_before = fill_count;
        access(1'b0, 30'h000, '0);
        if (fill_count != fills_before + 1) begin
            report_failure("first read after reset did not fetch the line");
        end
        @(negedge clk);
        check_value("proc_stall", 32'(proc_stall), 32'd0);  // COMP with no request
        @(posedge clk);
        #1;

        // write then read in line 2
        access(1'b1, 30'h009, 32'hDEAD_BEEF);
        access(1'b0, 30'h009, '0);
        fills_before = fill_count;
        access(1'b0, 30'h00A, '0);
        if (fill_count != fills_before) begin
            report_failure("second read of a cached line went to memory");
        end

        // dirty eviction in set 3 with lines 3, 7 and 11
        access(1'b1, 30'h00E, 32'h1234_5678);
        access(1'b0, 30'h01C, '0);
        wbs_before = wb_count;
        access(1'b0, 30'h02C, '0);  // evicts dirty line 3
        if (wb_count != wbs_before + 1) begin
            report_failure("dirty line was not written back on eviction");
        end
        check_value("mem_addr", 32'(last_wb_addr), 32'h3);
        access(1'b0, 30'h00E, '0);

        // LRU in set 1 with A in line 1, B in line 5 and C in line 9
        access(1'b0, 30'h004, '0);
        access(1'b0, 30'h014, '0);
        access(1'b0, 30'h004, '0);  // B now least recent
        fills_before = fill_count;
        access(1'b0, 30'h024, '0);
        if (fill_count != fills_before + 1) begin
            report_failure("read of a new line did not fetch it");
        end
        fills_before = fill_count;
        access(1'b0, 30'h004, '0);
        if (fill_count != fills_before) begin
            report_failure("recently used line was evicted instead of the least recent one");
        end
        access(1'b0, 30'h014, '0);
        if (fill_count != fills_before + 1) begin
            report_failure("line that should have been evicted still hit");
        end

        // random stream over lines 0 to 15
        for (int i = 0; i < 200; i++) begin
            rnd_op   = take_bits(1);
            rnd_addr = word_addr_t'(take_bits(6));
            rnd_data = take_bits(32);
            access(rnd_op[0], rnd_addr, rnd_data);
        end

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
cache_pkg.sv
cache_if.sv
cache_store.sv
cache_ctrl.sv
cache_top.sv
tb_cache.sv
